// File: prach_pkg.sv
// one carrier and four antennas fixed here; the saturating helpers assume 16-bit signed parts
`default_nettype none

package prach_pkg;

   ////////////////////////////////////////
   // sizes
   ////////////////////////////////////////

   // bits per i or q component
   localparam int precision        = 16;
   localparam int n_antennas       = 4;
   localparam int ant_bw           = 2;
   // phase accumulator and increment
   localparam int nco_coef_width   = 40;
   // gain = scalar.fraction, unsigned
   localparam int gain_scaler_bw   = 4;
   localparam int gain_fraction_bw = 16;

   // signed component limits
   localparam logic signed [precision-1:0] sample_max = 16'sh7fff;
   localparam logic signed [precision-1:0] sample_min = 16'sh8000;

   ////////////////////////////////////////
   // sample word
   ////////////////////////////////////////

   // q sits in the upper half
   typedef struct packed {
      logic signed [precision-1:0] q;
      logic signed [precision-1:0] i;
   } iq_pair_t;

   // same 32 bits, raw or as i/q
   typedef union packed {
      logic [2*precision-1:0] raw;
      iq_pair_t               iq;
   } iq_word_t;

   ////////////////////////////////////////
   // saturating helpers
   ////////////////////////////////////////

   // -(-32768) has no 16-bit form, so it pins to max
   function automatic logic signed [precision-1:0] sat_negate(
      input logic signed [precision-1:0] x);
      return (x == sample_min) ? sample_max : -x;
   endfunction

   // clip a 32-bit signed value into the component range
   function automatic logic signed [precision-1:0] sat_clip(
      input logic signed [2*precision-1:0] x);
      if (x > sample_max) return sample_max;
      if (x < sample_min) return sample_min;
      return x[precision-1:0];
   endfunction

endpackage

`default_nettype wire

// File: prach_antenna_collect.sv
// samples must arrive in antenna order 0..3; out-of-order tags are dropped, never reordered
`timescale 1ns/10ps
`default_nettype none

module prach_antenna_collect
   import prach_pkg::*;
(
   input  wire logic                      clk_4x,
   input  wire logic                      resetn_4x,
   // tagged input samples, one per cycle at most
   input  wire logic                      in_valid,
   input  wire iq_word_t                  in_data,
   input  wire logic [ant_bw-1:0]         in_ant,
   // gathered frame
   output      logic                      frame_valid,
   output      iq_word_t [n_antennas-1:0] frame_data,
   output      logic                      drop_strobe
);

   ////////////////////////////////////////
   // antenna order check
   ////////////////////////////////////////

   // next antenna the frame is waiting for
   logic [ant_bw-1:0] exp_ant;
   logic              accept;
   logic              reject;
   logic              last_ant;

   // tag match against the expected count
   assign accept   = in_valid && (in_ant == exp_ant);
   assign reject   = in_valid && (in_ant != exp_ant);
   // last lane closes the frame
   assign last_ant = (exp_ant == ant_bw'(n_antennas - 1));

   ////////////////////////////////////////
   // control
   ////////////////////////////////////////

   always_ff @(posedge clk_4x) begin
      if (!resetn_4x) begin
         exp_ant     <= '0;
         frame_valid <= 1'b0;
         drop_strobe <= 1'b0;
      end else begin
         // one pulse per rejected sample
         drop_strobe <= reject;
         // frame strobe only when the last lane lands
         frame_valid <= accept && last_ant;
         if (accept) begin
            // wrap back to antenna 0 after the last one
            if (last_ant) begin
               exp_ant <= '0;
            end else begin
               exp_ant <= exp_ant + 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////
   // lane storage
   ////////////////////////////////////////

   // lanes are overwritten in place as the next frame builds up
   // execute samples them on the frame_valid edge, before lane 0 moves
   always_ff @(posedge clk_4x) begin
      if (accept) begin
         frame_data[exp_ant].raw <= in_data.raw;
      end
   end

endmodule

`default_nettype wire

// File: prach_quadrant_mixer.sv
// NCO limited to quarter-turn steps from the top two phase bits; finer phase bits only accumulate
`timescale 1ns/10ps
`default_nettype none

module prach_quadrant_mixer
   import prach_pkg::*;
(
   input  wire logic                      clk_4x,
   input  wire logic                      resetn_4x,
   // frame from decode
   input  wire logic                      frame_valid,
   input  wire iq_word_t [n_antennas-1:0] frame_data,
   // phase step per frame, held while frames are in flight
   input  wire logic [nco_coef_width-1:0] nco_coef,
   // rotated frame
   output      logic                      mix_valid,
   output      iq_word_t [n_antennas-1:0] mix_data
);

   // frame n sees n * nco_coef
   logic [nco_coef_width-1:0] phase_acc;
   logic [1:0]                quadrant;

   // top two bits pick the quarter turn
   assign quadrant = phase_acc[nco_coef_width-1 -: 2];

   ////////////////////////////////////////
   // quarter-turn rotation
   ////////////////////////////////////////

   // multiply by j^quad, negations saturate
   function automatic iq_word_t rotate_lane(input iq_word_t x, input logic [1:0] quad);
      iq_word_t y;
      case (quad)
         // 0 deg
         2'd0: y.raw = x.raw;
         // 90 deg
         2'd1: begin
            y.iq.i = sat_negate(x.iq.q);
            y.iq.q = x.iq.i;
         end
         // 180 deg
         2'd2: begin
            y.iq.i = sat_negate(x.iq.i);
            y.iq.q = sat_negate(x.iq.q);
         end
         // 270 deg
         default: begin
            y.iq.i = x.iq.q;
            y.iq.q = sat_negate(x.iq.i);
         end
      endcase
      return y;
   endfunction

   ////////////////////////////////////////
   // phase and strobe
   ////////////////////////////////////////

   always_ff @(posedge clk_4x) begin
      if (!resetn_4x) begin
         phase_acc <= '0;
         mix_valid <= 1'b0;
      end else begin
         mix_valid <= frame_valid;
         // step after the frame has used the current phase
         if (frame_valid) begin
            phase_acc <= phase_acc + nco_coef;
         end
      end
   end

   // same quadrant for every lane of a frame
   always_ff @(posedge clk_4x) begin
      if (frame_valid) begin
         for (int k = 0; k < n_antennas; k++) begin
            mix_data[k] <= rotate_lane(frame_data[k], quadrant);
         end
      end
   end

endmodule

`default_nettype wire

// File: prach_gain_serializer.sv
// frames must be at least four cycles apart; a frame arriving mid-burst would cut the burst short
`timescale 1ns/10ps
`default_nettype none

module prach_gain_serializer
   import prach_pkg::*;
(
   input  wire logic                        clk_4x,
   input  wire logic                        resetn_4x,
   // rotated frame from execute
   input  wire logic                        mix_valid,
   input  wire iq_word_t [n_antennas-1:0]   mix_data,
   // channel gain, scalar.fraction plus sign
   input  wire logic [gain_scaler_bw-1:0]   gain_scalar,
   input  wire logic [gain_fraction_bw-1:0] gain_fraction,
   input  wire logic                        gain_sign,
   // serialized output
   output      logic                        out_valid,
   output      iq_word_t                    out_data,
   output      logic [ant_bw-1:0]           out_ant
);

   ////////////////////////////////////////
   // gain arithmetic
   ////////////////////////////////////////

   // scalar * 65536 + fraction, zero-extended to stay positive
   logic signed [gain_scaler_bw+gain_fraction_bw:0] gain_word;

   assign gain_word = {1'b0, gain_scalar, gain_fraction};

   // one component: multiply, drop the fraction, clip, optional invert
   function automatic logic signed [precision-1:0] apply_gain(
      input logic signed [precision-1:0]                 x,
      input logic signed [gain_scaler_bw+gain_fraction_bw:0] g,
      input logic                                        neg);
      logic signed [precision+gain_scaler_bw+gain_fraction_bw:0] prod;
      logic signed [precision+gain_scaler_bw+gain_fraction_bw:0] shifted;
      logic signed [precision-1:0]                               clipped;
      prod    = x * g;
      // arithmetic shift, rounds toward minus infinity
      shifted = prod >>> gain_fraction_bw;
      // magnitude fits in 21 bits, so the low 32 carry the value
      clipped = sat_clip($signed(shifted[2*precision-1:0]));
      return neg ? sat_negate(clipped) : clipped;
   endfunction

   ////////////////////////////////////////
   // frame hold and lane select
   ////////////////////////////////////////

   iq_word_t [n_antennas-1:0] hold_data;
   // lane to emit on the next cycle while busy
   logic [ant_bw-1:0]         next_ant;
   logic                      busy;
   iq_word_t                  src;
   iq_word_t                  gained;

   // lane 0 goes straight from the incoming frame, the rest from the hold
   always_comb begin
      if (mix_valid) begin
         src = mix_data[0];
      end else begin
         src = hold_data[next_ant];
      end
      gained.iq.i = apply_gain(src.iq.i, gain_word, gain_sign);
      gained.iq.q = apply_gain(src.iq.q, gain_word, gain_sign);
   end

   always_ff @(posedge clk_4x) begin
      if (mix_valid) begin
         hold_data <= mix_data;
      end
   end

   ////////////////////////////////////////
   // output sequencing
   ////////////////////////////////////////

   always_ff @(posedge clk_4x) begin
      if (!resetn_4x) begin
         out_valid <= 1'b0;
         out_ant   <= '0;
         next_ant  <= '0;
         busy      <= 1'b0;
      end else if (mix_valid) begin
         // antenna 0 now, 1..3 follow back to back
         out_valid <= 1'b1;
         out_ant   <= '0;
         next_ant  <= ant_bw'(1);
         busy      <= 1'b1;
      end else if (busy) begin
         out_valid <= 1'b1;
         out_ant   <= next_ant;
         next_ant  <= next_ant + 1'b1;
         // done after the last antenna
         if (next_ant == ant_bw'(n_antennas - 1)) begin
            busy <= 1'b0;
         end
      end else begin
         out_valid <= 1'b0;
      end
   end

   // payload only moves when a lane is emitted
   always_ff @(posedge clk_4x) begin
      if (mix_valid || busy) begin
         out_data.raw <= gained.raw;
      end
   end

endmodule

`default_nettype wire

// File: prach_dfe_top.sv
// single carrier, single clock; config inputs must only change while no frame is in flight
`timescale 1ns/10ps
`default_nettype none

module prach_dfe_top
   import prach_pkg::*;
(
   input  wire logic                        clk_4x,
   input  wire logic                        resetn_4x,
   // tagged sample stream, no back-pressure
   input  wire logic                        in_valid,
   input  wire iq_word_t                    in_data,
   input  wire logic [ant_bw-1:0]           in_ant,
   // static configuration
   input  wire logic [nco_coef_width-1:0]   nco_coef,
   input  wire logic [gain_scaler_bw-1:0]   gain_scalar,
   input  wire logic [gain_fraction_bw-1:0] gain_fraction,
   input  wire logic                        gain_sign,
   // serialized result
   output      logic                        out_valid,
   output      iq_word_t                    out_data,
   output      logic [ant_bw-1:0]           out_ant,
   // rejected sample pulse
   output      logic                        drop_strobe
);

   // decode to execute
   logic                      frame_valid;
   iq_word_t [n_antennas-1:0] frame_data;
   // execute to result
   logic                      mix_valid;
   iq_word_t [n_antennas-1:0] mix_data;

   ////////////////////////////////////////
   // decode, execute, result
   ////////////////////////////////////////

   // frame_valid at t+1
   prach_antenna_collect u_collect (
      .clk_4x      (clk_4x),
      .resetn_4x   (resetn_4x),
      .in_valid    (in_valid),
      .in_data     (in_data),
      .in_ant      (in_ant),
      .frame_valid (frame_valid),
      .frame_data  (frame_data),
      .drop_strobe (drop_strobe)
   );

   // mix_valid at t+2
   prach_quadrant_mixer u_mixer (
      .clk_4x      (clk_4x),
      .resetn_4x   (resetn_4x),
      .frame_valid (frame_valid),
      .frame_data  (frame_data),
      .nco_coef    (nco_coef),
      .mix_valid   (mix_valid),
      .mix_data    (mix_data)
   );

   // antennas out at t+3..t+6
   prach_gain_serializer u_gain (
      .clk_4x        (clk_4x),
      .resetn_4x     (resetn_4x),
      .mix_valid     (mix_valid),
      .mix_data      (mix_data),
      .gain_scalar   (gain_scalar),
      .gain_fraction (gain_fraction),
      .gain_sign     (gain_sign),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .out_ant       (out_ant)
   );

endmodule

`default_nettype wire

// File: tb_prach_ref.svh
// integer reference for the quarter-turn rotation and channel gain; 16-bit signed i/q parts only
`ifndef TB_PRACH_REF_SVH
`define TB_PRACH_REF_SVH

// negation pinned to the 16-bit range
function automatic int negate_pinned(input int x);
   int y;
   y = -x;
   if (y > 32767) begin
      y = 32767;
   end
   return y;
endfunction

// clip to the 16-bit signed range
function automatic int clip16(input longint x);
   if (x > 32767) return 32767;
   if (x < -32768) return -32768;
   return int'(x);
endfunction

// gain = scalar + fraction/65536, result floored, clipped, then optionally inverted
function automatic int scale_by_gain(input int x, input int scalar, input int fraction,
                                     input bit neg);
   longint p;
   longint s;
   int     c;
   p = longint'(x) * (longint'(scalar) * 65536 + longint'(fraction));
   // floor rather than truncation toward zero
   s = p / 65536;
   if (p < 0 && (p % 65536) != 0) begin
      s = s - 1;
   end
   c = clip16(s);
   if (neg) begin
      c = negate_pinned(c);
   end
   return c;
endfunction

// one expected output word with q in the upper half
function automatic logic [31:0] expected_word(input logic [31:0] w, input int quad,
                                              input int scalar, input int fraction, input bit neg);
   int i;
   int q;
   int ri;
   int rq;
   i = int'($signed(w[15:0]));
   q = int'($signed(w[31:16]));
   // multiply by j^quad
   case (quad)
      0: begin
         ri = i;
         rq = q;
      end
      1: begin
         ri = negate_pinned(q);
         rq = i;
      end
      2: begin
         ri = negate_pinned(i);
         rq = negate_pinned(q);
      end
      default: begin
         ri = q;
         rq = negate_pinned(i);
      end
   endcase
   ri = scale_by_gain(ri, scalar, fraction, neg);
   rq = scale_by_gain(rq, scalar, fraction, neg);
   return {16'(rq), 16'(ri)};
endfunction

`endif

// File: tb_prach_dfe.sv
// single clock 25 MHz testbench; config only changes while the pipeline is idle
`timescale 1ns/10ps
`default_nettype none

module tb_prach_dfe
   import prach_pkg::*;
();

`include "tb_prach_ref.svh"

   localparam int n_rand_frames = 48;
   // cycles per frame for four samples, a gap and the drain
   localparam int frame_cycles  = 16;
   localparam int stim_cycles   = 4 * 8 + (n_rand_frames + 16) * frame_cycles;
   localparam int wd_margin     = 100;

   logic                        clk_4x;
   logic                        resetn_4x;
   logic                        in_valid;
   iq_word_t                    in_data;
   logic [ant_bw-1:0]           in_ant;
   logic [nco_coef_width-1:0]   nco_coef;
   logic [gain_scaler_bw-1:0]   gain_scalar;
   logic [gain_fraction_bw-1:0] gain_fraction;
   logic                        gain_sign;
   logic                        out_valid;
   iq_word_t                    out_data;
   logic [ant_bw-1:0]           out_ant;
   logic                        drop_strobe;

   // bit k of sched is out_valid registered k edges ahead
   logic [7:0]                  sched;
   logic                        exp_vld;
   logic                        exp_drop;
   logic [33:0]                 exp_head;
   logic [33:0]                 sb [$];
   int                          m_exp_ant;
   logic [nco_coef_width-1:0]   m_phase;
   logic [31:0]                 m_lane [n_antennas];
   int                          value_errs  = 0;
   int                          timing_errs = 0;
   int                          other_errs  = 0;

   prach_dfe_top dut0 (
      .clk_4x        (clk_4x),
      .resetn_4x     (resetn_4x),
      .in_valid      (in_valid),
      .in_data       (in_data),
      .in_ant        (in_ant),
      .nco_coef      (nco_coef),
      .gain_scalar   (gain_scalar),
      .gain_fraction (gain_fraction),
      .gain_sign     (gain_sign),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .out_ant       (out_ant),
      .drop_strobe   (drop_strobe)
   );

   initial begin
      clk_4x = 1'b0;
      forever #20 clk_4x = ~clk_4x;
   end

   ////////////////////////////////////////
   // reference model and scoreboard
   ////////////////////////////////////////

   always @(posedge clk_4x) begin : model
      logic [7:0] s;
      int         quad;
      s = sched;
      if (!resetn_4x) begin
         m_exp_ant = 0;
         m_phase   = '0;
         sb.delete();
         s         = '0;
         exp_drop <= 1'b0;
      end else begin
         // head entry was compared at this edge
         if (exp_vld && sb.size() > 0) begin
            void'(sb.pop_front());
         end
         exp_drop <= in_valid && (int'(in_ant) != m_exp_ant);
         if (in_valid && int'(in_ant) == m_exp_ant) begin
            m_lane[m_exp_ant] = in_data.raw;
            if (m_exp_ant == n_antennas - 1) begin
               quad = int'(m_phase[nco_coef_width-1 -: 2]);
               for (int k = 0; k < n_antennas; k++) begin
                  sb.push_back({2'(k), expected_word(m_lane[k], quad, int'(gain_scalar),
                                                     int'(gain_fraction), gain_sign)});
               end
               m_phase   = m_phase + nco_coef;
               m_exp_ant = 0;
               // outputs registered at t+2..t+5 and seen at t+3..t+6
               s = s | 8'b0011_1100;
            end else begin
               m_exp_ant++;
            end
         end
      end
      exp_vld  <= s[0];
      sched    <= s >> 1;
      exp_head <= (sb.size() > 0) ? sb[0] : '0;
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   a_out_valid: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      out_valid == exp_vld)
      else begin
         timing_errs++;
         $display("error at %0t: out_valid expected %0b actual %0b", $time,
                  $sampled(exp_vld), $sampled(out_valid));
      end

   a_drop: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      drop_strobe == exp_drop)
      else begin
         timing_errs++;
         $display("error at %0t: drop_strobe expected %0b actual %0b", $time,
                  $sampled(exp_drop), $sampled(drop_strobe));
      end

   a_out_ant: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      exp_vld |-> out_ant == exp_head[33:32])
      else begin
         value_errs++;
         $display("error at %0t: out_ant expected %0d actual %0d", $time,
                  $sampled(exp_head[33:32]), $sampled(out_ant));
      end

   a_out_data: assert property (@(posedge clk_4x) disable iff (!resetn_4x)
      exp_vld |-> out_data.raw == exp_head[31:0])
      else begin
         value_errs++;
         $display("error at %0t: out_data expected %h actual %h", $time,
                  $sampled(exp_head[31:0]), $sampled(out_data.raw));
      end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   task automatic apply_reset();
      @(posedge clk_4x);
      resetn_4x <= 1'b0;
      repeat (8) @(posedge clk_4x);
      resetn_4x <= 1'b1;
   endtask

   task automatic send_sample(input int ant, input logic [31:0] w);
      @(posedge clk_4x);
      in_valid    <= 1'b1;
      in_ant      <= ant_bw'(ant);
      in_data.raw <= w;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk_4x);
         in_valid <= 1'b0;
      end
   endtask

   // lane k in bits 32k+31..32k
   task automatic send_frame(input logic [127:0] lanes);
      for (int k = 0; k < n_antennas; k++) begin
         send_sample(k, lanes[32*k +: 32]);
      end
      idle_cycles(1);
   endtask

   task automatic wait_idle();
      int n;
      for (n = 0; n < 32; n++) begin
         @(posedge clk_4x);
         if (sched == '0 && !exp_vld && !out_valid) break;
      end
      if (n == 32) begin
         other_errs++;
         $display("pipeline still busy 32 cycles after the last frame");
      end
   endtask

   initial begin
      void'($urandom(32'h84e5));
      resetn_4x     = 1'b0;
      in_valid      = 1'b0;
      in_data       = '0;
      in_ant        = '0;
      nco_coef      = '0;
      gain_scalar   = 4'd1;
      gain_fraction = '0;
      gain_sign     = 1'b0;
      apply_reset();
      idle_cycles(6);
      // no phase and unity gain
      repeat (4) begin
         send_frame({$urandom, $urandom, $urandom, $urandom});
         wait_idle();
      end
      // quarter turn per frame with edge values
      @(posedge clk_4x);
      nco_coef <= 40'h40_0000_0000;
      repeat (4) begin
         send_frame({32'h8000_8000, 32'h8000_1234, 32'h7fff_8000, 32'h0001_ffff});
         wait_idle();
      end
      // random gain and phase with clipping likely at high scalars
      repeat (n_rand_frames) begin
         @(posedge clk_4x);
         nco_coef      <= 40'({$urandom, $urandom});
         gain_scalar   <= 4'($urandom);
         gain_fraction <= 16'($urandom);
         gain_sign     <= 1'($urandom);
         send_frame({$urandom, $urandom, $urandom, $urandom});
         wait_idle();
      end
      // out of order tags that must be dropped
      send_sample(0, $urandom);
      send_sample(2, $urandom);
      send_sample(1, $urandom);
      send_sample(3, $urandom);
      send_sample(0, $urandom);
      send_sample(2, $urandom);
      send_sample(3, $urandom);
      idle_cycles(1);
      wait_idle();
      // mid-run reset with phase advanced and a half frame pending
      @(posedge clk_4x);
      nco_coef <= 40'h40_0000_0000;
      repeat (2) begin
         send_frame({$urandom, $urandom, $urandom, $urandom});
         wait_idle();
      end
      send_sample(0, $urandom);
      send_sample(1, $urandom);
      idle_cycles(1);
      apply_reset();
      send_frame({32'h8000_8000, 32'h1234_5678, 32'hffff_0001, 32'h7fff_8000});
      wait_idle();
      idle_cycles(4);
      $display("errors: %0d value, %0d timing, %0d other", value_errs, timing_errs, other_errs);
      if (value_errs + timing_errs + other_errs == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #((stim_cycles + wd_margin) * 40);
      $display("watchdog expired after %0d cycles", stim_cycles + wd_margin);
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
prach_pkg.sv
prach_antenna_collect.sv
prach_quadrant_mixer.sv
prach_gain_serializer.sv
prach_dfe_top.sv
tb_prach_dfe.sv

// File: Makefile
# Verilator build and run of the PRACH front end testbench

.PHONY: all compile run clean

all: run

compile: obj_dir/sim_prach

obj_dir/sim_prach: vlog.f *.sv *.svh
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module tb_prach_dfe -Mdir obj_dir -o sim_prach

run: compile
	./obj_dir/sim_prach | tee sim.log
	@if grep -q "sim failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
